// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    localparam int xlen    = 64;    // data and address width
    localparam int word_w  = 32;    // operand width of the *w instructions
    localparam int shamt_w = 6;     // enough to count 0..63

    typedef logic [xlen-1:0]    data_t;     // data, pc and jump targets
    typedef logic [xlen:0]      data_ext_t; // alu result plus sign or borrow bit
    typedef logic [shamt_w-1:0] shamt_t;

    typedef logic [2:0] alu_op_t;
    typedef logic [2:0] comp_type_t;
    typedef logic [1:0] shift_type_t;

    localparam alu_op_t alu_add = 3'd0;
    localparam alu_op_t alu_sub = 3'd1;
    localparam alu_op_t alu_and = 3'd2;
    localparam alu_op_t alu_or  = 3'd3;
    localparam alu_op_t alu_xor = 3'd4; // highest legal alu code

    localparam comp_type_t comp_eq  = 3'd0;
    localparam comp_type_t comp_ne  = 3'd1;
    localparam comp_type_t comp_lt  = 3'd2;
    localparam comp_type_t comp_ge  = 3'd3;
    localparam comp_type_t comp_ltu = 3'd4;
    localparam comp_type_t comp_geu = 3'd5; // highest legal compare code

    localparam shift_type_t shift_sll = 2'd0;
    localparam shift_type_t shift_srl = 2'd1;
    localparam shift_type_t shift_sra = 2'd2;

    // decoded control for one instruction in the execute stage
    typedef struct packed {
        logic        alu_src_pc;    // operand a is the pc
        logic        alu_src_imm;   // operand b is the immediate
        alu_op_t     alu_op;
        logic        inst_word;     // 32-bit variant, result sign-extended
        logic        inst_branch;   // conditional branch
        logic        inst_sltxx;    // slt, slti, sltu, sltiu
        comp_type_t  comp_type;
        logic        inst_shift;
        shift_type_t shift_type;
        logic        shift_num_src; // shift amount from imm_shift
    } ex_ctrl_t;

    // operands delivered by decode and the register file
    typedef struct packed {
        data_t  pc;
        data_t  rs1_data;
        data_t  rs2_data;
        data_t  imm_data;   // already sign-extended by decode
        shamt_t imm_shift;
    } ex_data_t;

    // what leaves the execute stage
    typedef struct packed {
        data_t jump_addr;
        data_t odata;
        logic  branch_taken;
    } ex_res_t;

endpackage

// ==== verilog/ex_alu.sv ====
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::ex_ctrl_t  ctrl,
    input  ex_pkg::data_t     pc,
    input  ex_pkg::data_t     op1_data,
    input  ex_pkg::data_t     op2_data,
    input  ex_pkg::data_t     imm_data,
    output ex_pkg::data_ext_t alu_res
);

    ex_pkg::data_t     opa;
    ex_pkg::data_t     opb;
    ex_pkg::data_ext_t opa_ext;
    ex_pkg::data_ext_t opb_ext;
    ex_pkg::data_t     logic_res;
    logic              compare;
    logic              comp_signed;
    logic              ext_signed;

    assign opa = ctrl.alu_src_pc  ? pc       : op1_data;
    assign opb = ctrl.alu_src_imm ? imm_data : op2_data;

    assign compare     = ctrl.inst_branch | ctrl.inst_sltxx;    // these always subtract
    assign comp_signed = (ctrl.comp_type == ex_pkg::comp_lt) ||
                         (ctrl.comp_type == ex_pkg::comp_ge);
    assign ext_signed  = compare ? comp_signed : 1'b1;

    // zero extension turns bit 64 of the difference into the unsigned borrow
    assign opa_ext = {ext_signed & opa[ex_pkg::xlen-1], opa};
    assign opb_ext = {ext_signed & opb[ex_pkg::xlen-1], opb};

    always_comb begin
        logic_res = '0;
        unique case (ctrl.alu_op)
            ex_pkg::alu_and: logic_res = opa & opb;
            ex_pkg::alu_or:  logic_res = opa | opb;
            ex_pkg::alu_xor: logic_res = opa ^ opb;
            default:         logic_res = '0;
        endcase
    end

    always_comb begin
        if (compare) begin
            alu_res = opa_ext - opb_ext;
        end else begin
            case (ctrl.alu_op)
                ex_pkg::alu_add: alu_res = opa_ext + opb_ext;
                ex_pkg::alu_sub: alu_res = opa_ext - opb_ext;
                default:         alu_res = {logic_res[ex_pkg::xlen-1], logic_res};
            endcase
        end
    end

    // decode must never hand over an unused operation code
    always_comb begin
        if (!$isunknown(ctrl.alu_op)) begin
            assert (ctrl.alu_op <= ex_pkg::alu_xor)
                else $error("ex_alu: illegal alu_op %0d", ctrl.alu_op);
        end
    end

endmodule

// ==== verilog/ex_branchjudge.sv ====
`timescale 1ns/1ps

module ex_branchjudge (
    input  ex_pkg::comp_type_t comp_type,
    input  ex_pkg::data_ext_t  alu_res,     // extended difference rs1 - rs2
    output logic               judge_res
);

    logic is_zero;
    logic is_less;

    assign is_zero = ~|alu_res[ex_pkg::xlen-1:0];
    assign is_less = alu_res[ex_pkg::xlen];    // sign for signed, borrow for unsigned

    always_comb begin
        case (comp_type)
            ex_pkg::comp_eq:  judge_res = is_zero;
            ex_pkg::comp_ne:  judge_res = ~is_zero;
            ex_pkg::comp_lt:  judge_res = is_less;
            ex_pkg::comp_ltu: judge_res = is_less;  // alu zero-extended the operands
            ex_pkg::comp_ge:  judge_res = ~is_less;
            ex_pkg::comp_geu: judge_res = ~is_less;
            default:          judge_res = 1'b0;
        endcase
    end

    // the alu picks its extension from the same code, so both must agree on it
    always_comb begin
        if (!$isunknown(comp_type)) begin
            assert (comp_type <= ex_pkg::comp_geu)
                else $error("ex_branchjudge: illegal comp_type %0d", comp_type);
        end
    end

endmodule

// ==== verilog/ex_shifter.sv ====
`timescale 1ns/1ps

module ex_shifter (
    input  ex_pkg::shift_type_t shift_type,
    input  logic                inst_word,
    input  logic                shift_num_src,
    input  ex_pkg::data_t       rs1_data,
    input  ex_pkg::data_t       rs2_data,
    input  ex_pkg::shamt_t      imm_shift,
    output ex_pkg::data_t       shift_res
);

    ex_pkg::shamt_t            amount;
    logic [4:0]                amount_w;
    logic [ex_pkg::word_w-1:0] src_w;
    logic [ex_pkg::word_w-1:0] res_w;
    ex_pkg::data_t             res_d;

    assign amount   = shift_num_src ? imm_shift : rs2_data[ex_pkg::shamt_w-1:0];
    assign amount_w = amount[4:0];             // word shifts ignore bit 5
    assign src_w    = rs1_data[ex_pkg::word_w-1:0];

    always_comb begin
        case (shift_type)
            ex_pkg::shift_sll: res_w = src_w << amount_w;
            ex_pkg::shift_srl: res_w = src_w >> amount_w;   // zero fill from bit 31
            ex_pkg::shift_sra: res_w = $signed(src_w) >>> amount_w;
            default:           res_w = '0;
        endcase
    end

    always_comb begin
        case (shift_type)
            ex_pkg::shift_sll: res_d = rs1_data << amount;
            ex_pkg::shift_srl: res_d = rs1_data >> amount;
            ex_pkg::shift_sra: res_d = $signed(rs1_data) >>> amount;
            default:           res_d = '0;
        endcase
    end

    // upper half of a word result is refilled by ex_top
    assign shift_res = inst_word ? {{(ex_pkg::xlen-ex_pkg::word_w){1'b0}}, res_w} : res_d;

    // slliw and friends with shamt[5] set are reserved encodings
    always_comb begin
        if (!$isunknown({inst_word, shift_num_src}) && inst_word && shift_num_src) begin
            assert (imm_shift < 6'd32)
                else $error("ex_shifter: word shift by immediate %0d", imm_shift);
        end
    end

endmodule

// ==== verilog/ex_top.sv ====
`timescale 1ns/1ps

module ex_top (
    input  ex_pkg::ex_ctrl_t ctrl,
    input  ex_pkg::ex_data_t data,
    output ex_pkg::ex_res_t  res
);

    ex_pkg::data_t     op1_data;
    ex_pkg::data_t     op2_data;
    ex_pkg::data_ext_t alu_res;
    ex_pkg::data_t     shift_res;
    ex_pkg::data_t     odata_pre;
    logic              judge_res;

    function automatic ex_pkg::data_t sext_word(input ex_pkg::data_t value);
        return {{(ex_pkg::xlen-ex_pkg::word_w){value[ex_pkg::word_w-1]}},
                value[ex_pkg::word_w-1:0]};
    endfunction

    // *w instructions work on the sign-extended low halves
    assign op1_data = ctrl.inst_word ? sext_word(data.rs1_data) : data.rs1_data;
    assign op2_data = ctrl.inst_word ? sext_word(data.rs2_data) : data.rs2_data;

    ex_alu u_alu (
        .ctrl     (ctrl),
        .pc       (data.pc),
        .op1_data (op1_data),
        .op2_data (op2_data),
        .imm_data (data.imm_data),
        .alu_res  (alu_res)
    );

    ex_branchjudge u_branchjudge (
        .comp_type (ctrl.comp_type),
        .alu_res   (alu_res),
        .judge_res (judge_res)
    );

    ex_shifter u_shifter (
        .shift_type    (ctrl.shift_type),
        .inst_word     (ctrl.inst_word),
        .shift_num_src (ctrl.shift_num_src),
        .rs1_data      (data.rs1_data),    // word mode reads only bits 31:0
        .rs2_data      (data.rs2_data),
        .imm_shift     (data.imm_shift),
        .shift_res     (shift_res)
    );

    always_comb begin
        if (ctrl.inst_shift) begin
            odata_pre = shift_res;
        end else if (ctrl.inst_sltxx) begin
            odata_pre = {{(ex_pkg::xlen-1){1'b0}}, judge_res};
        end else begin
            odata_pre = alu_res[ex_pkg::xlen-1:0];
        end
    end

    assign res.odata        = ctrl.inst_word ? sext_word(odata_pre) : odata_pre;
    assign res.jump_addr    = alu_res[ex_pkg::xlen-1:0];    // pc+imm or rs1+imm
    assign res.branch_taken = ctrl.inst_branch & judge_res;

    // decode sets at most one result source
    always_comb begin
        if (!$isunknown({ctrl.inst_shift, ctrl.inst_sltxx})) begin
            assert (!(ctrl.inst_shift && ctrl.inst_sltxx))
                else $error("ex_top: inst_shift and inst_sltxx both set");
        end
    end

endmodule

// ==== verilog/ex_stage_reg.sv ====
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             stall,
    input  logic             flush,
    input  logic             in_valid,
    input  ex_pkg::ex_ctrl_t in_ctrl,
    input  ex_pkg::ex_data_t in_data,
    output logic             held_valid,
    output ex_pkg::ex_ctrl_t held_ctrl,
    output ex_pkg::ex_data_t held_data
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held_valid <= 1'b0;
            held_ctrl  <= '0;
            held_data  <= '0;
        end else if (flush) begin
            held_valid <= 1'b0;     // kills the instruction even while stalled
        end else if (!stall) begin
            held_valid <= in_valid;
            held_ctrl  <= in_ctrl;
            held_data  <= in_data;
        end
    end

    // a flushed instruction must not reach the next stage
    a_flush_kills: assert property (
        @(posedge clk) disable iff (!rst_n) flush |=> !held_valid
    ) else $error("ex_stage_reg: held_valid set the cycle after flush");

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  ex_pkg::ex_ctrl_t in_ctrl,
    input  ex_pkg::ex_data_t in_data,
    input  logic             stall,     // later stage cannot take a result
    input  logic             flush,
    output logic             out_valid,
    output ex_pkg::ex_res_t  out_res
);

    logic             held_valid;
    ex_pkg::ex_ctrl_t held_ctrl;
    ex_pkg::ex_data_t held_data;
    ex_pkg::ex_res_t  ex_res;

    ex_stage_reg u_stage_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .in_valid   (in_valid),
        .in_ctrl    (in_ctrl),
        .in_data    (in_data),
        .held_valid (held_valid),
        .held_ctrl  (held_ctrl),
        .held_data  (held_data)
    );

    ex_top u_ex_top (
        .ctrl (held_ctrl),
        .data (held_data),
        .res  (ex_res)
    );

    assign out_valid = held_valid;
    assign out_res   = ex_res;      // combinational off the held operands

endmodule

// ==== dv/ex_checker.sv ====
`timescale 1ns/1ps

module ex_checker (
    input  logic            clk,
    input  logic            check_en,
    input  int              case_id,
    input  logic            exp_valid,
    input  ex_pkg::ex_res_t exp_res,
    input  logic [2:0]      check_mask,     // bit 0 odata, bit 1 jump_addr, bit 2 branch_taken
    input  logic            out_valid,
    input  ex_pkg::ex_res_t out_res,
    output int              pass_count,
    output int              error_count
);

    int case_errors;

    initial begin
        pass_count  = 0;
        error_count = 0;
        case_errors = 0;
    end

    task automatic compare_field(input string name, input ex_pkg::data_t got,
                                 input ex_pkg::data_t expected);
        if (got !== expected) begin
            $display("mismatch in case %0d: %s got %h expected %h",
                     case_id, name, got, expected);
            case_errors++;
        end
    endtask

    // outputs settle during the first half of the cycle, so compare on the falling edge
    always @(negedge clk) begin
        if (check_en) begin
            case_errors = 0;
            if (out_valid !== exp_valid) begin
                $display("mismatch in case %0d: out_valid got %h expected %h",
                         case_id, out_valid, exp_valid);
                case_errors++;
            end else if (exp_valid) begin
                if (check_mask[0]) begin
                    compare_field("odata", out_res.odata, exp_res.odata);
                end
                if (check_mask[1]) begin
                    compare_field("jump_addr", out_res.jump_addr, exp_res.jump_addr);
                end
                if (check_mask[2] && out_res.branch_taken !== exp_res.branch_taken) begin
                    $display("mismatch in case %0d: branch_taken got %h expected %h",
                             case_id, out_res.branch_taken, exp_res.branch_taken);
                    case_errors++;
                end
            end
            if (case_errors == 0) begin
                pass_count++;
                $display("case %0d: ok", case_id);
            end else begin
                error_count += case_errors;
                $display("case %0d: failed with %0d mismatch(es)", case_id, case_errors);
            end
        end
    end

endmodule

// ==== dv/ex_stage_tb.sv ====
`timescale 1ns/1ps

module ex_stage_tb;

    // one line of the case file after parsing
    typedef struct packed {
        ex_pkg::ex_ctrl_t ctrl;
        ex_pkg::ex_data_t data;
        logic             in_valid;
        logic             stall;
        logic             flush;
        logic             rnd;          // operands are don't care and get random values
        logic             exp_valid;
        ex_pkg::ex_res_t  exp_res;
        logic [2:0]       mask;         // which result fields are compared
    } case_t;

    logic             clk;
    logic             rst_n;
    logic             in_valid;
    ex_pkg::ex_ctrl_t in_ctrl;
    ex_pkg::ex_data_t in_data;
    logic             stall;
    logic             flush;
    logic             out_valid;
    ex_pkg::ex_res_t  out_res;

    logic             check_en;
    int               case_id;
    logic             exp_valid;
    ex_pkg::ex_res_t  exp_res;
    logic [2:0]       check_mask;
    int               pass_count;
    int               error_count;

    case_t  cases[$];
    int     n_cases = 0;
    integer seed = 32'hf015;
    bit     load_ok;

    ex_stage uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ctrl   (in_ctrl),
        .in_data   (in_data),
        .stall     (stall),
        .flush     (flush),
        .out_valid (out_valid),
        .out_res   (out_res)
    );

    ex_checker u_checker (
        .clk         (clk),
        .check_en    (check_en),
        .case_id     (case_id),
        .exp_valid   (exp_valid),
        .exp_res     (exp_res),
        .check_mask  (check_mask),
        .out_valid   (out_valid),
        .out_res     (out_res),
        .pass_count  (pass_count),
        .error_count (error_count)
    );

    always #10 clk = ~clk;

    task automatic load_cases(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [63:0] col [0:23];
        case_t       c;
        fd = $fopen("dv/ex_cases.txt", "r");
        ok = (fd != 0);
        if (fd == 0) begin
            $display("cannot open the case file dv/ex_cases.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line,
                        "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14],
                        col[15], col[16], col[17], col[18], col[19], col[20], col[21],
                        col[22], col[23]);
                    if (n != 24) begin
                        $display("malformed line in the case file: %s", line);
                        ok = 0;
                    end else begin
                        c.ctrl = {col[0][0], col[1][0], col[2][2:0], col[3][0], col[4][0],
                                  col[5][0], col[6][2:0], col[7][0], col[8][1:0], col[9][0]};
                        c.data      = {col[10], col[11], col[12], col[13], col[14][5:0]};
                        c.in_valid  = col[15][0];
                        c.stall     = col[16][0];
                        c.flush     = col[17][0];
                        c.rnd       = col[18][0];
                        c.exp_valid = col[19][0];
                        c.exp_res.odata        = col[20];
                        c.exp_res.jump_addr    = col[21];
                        c.exp_res.branch_taken = col[22][0];
                        c.mask      = col[23][2:0];
                        cases.push_back(c);
                    end
                end
            end
            $fclose(fd);
            n_cases = cases.size();
            if (n_cases == 0) ok = 0;
        end
    endtask

    task automatic drive_inputs(input case_t c);
        in_valid = c.in_valid;
        in_ctrl  = c.ctrl;
        in_data  = c.data;
        stall    = c.stall;
        flush    = c.flush;
        if (c.rnd) begin
            in_data.pc       = {$random(seed), $random(seed)};
            in_data.rs1_data = {$random(seed), $random(seed)};
            in_data.rs2_data = {$random(seed), $random(seed)};
            in_data.imm_data = {$random(seed), $random(seed)};
        end
    endtask

    // expected values go to the checker one cycle after their stimulus
    task automatic hand_expected(input int id, input case_t c);
        case_id    = id;
        exp_valid  = c.exp_valid;
        exp_res    = c.exp_res;
        check_mask = c.mask;
        check_en   = 1'b1;
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_ctrl    = '0;
        in_data    = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        check_en   = 1'b0;
        case_id    = 0;
        exp_valid  = 1'b0;
        exp_res    = '0;
        check_mask = '0;
        load_cases(load_ok);
        if (!load_ok) begin
            $display("the case file could not be read, no test ran");
            $display("Test failed");
        end else begin
            repeat (5) @(posedge clk);
            #2;
            rst_n = 1'b1;
            for (int i = 0; i < n_cases; i++) begin
                drive_inputs(cases[i]);
                @(posedge clk);
                #2;
                hand_expected(i, cases[i]);
            end
            @(posedge clk);
            #2;
            check_en = 1'b0;
            $display("%0d cases: %0d passed, %0d failed, %0d mismatches",
                     n_cases, pass_count, n_cases - pass_count, error_count);
            if (error_count == 0 && pass_count == n_cases) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

    // one clock period for every case and twenty more for reset and margin
    initial begin
        wait (n_cases > 0);
        #((n_cases + 20) * 20);
        $display("timeout: the cases did not finish in the expected time");
        $display("Test failed");
        $finish;
    end

endmodule

// ==== dv/ex_cases.txt ====
# srcpc srcimm aluop word br slt comp sh stype nsrc pc rs1 rs2 imm ishamt valid stall flush rand
# exp_valid odata jump taken mask (1 odata, 2 jump, 4 taken); rand=1 fills pc rs1 rs2 imm at random
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 5 7 0 0 1 0 0 0 1 c c 0 7
0 0 1 0 0 0 0 0 0 0 0 5 7 0 0 1 0 0 0 1 fffffffffffffffe fffffffffffffffe 0 7
0 0 2 0 0 0 0 0 0 0 0 f0f0 ff00 0 0 1 0 0 0 1 f000 f000 0 7
0 0 3 0 0 0 0 0 0 0 0 f0f0 ff00 0 0 1 0 0 0 1 fff0 fff0 0 7
0 0 4 0 0 0 0 0 0 0 0 f0f0 ff00 0 0 1 0 0 0 1 ff0 ff0 0 7
0 1 0 0 0 0 0 0 0 0 0 100 999 fffffffffffffff0 0 1 0 0 0 1 f0 f0 0 7
0 0 0 0 1 0 0 0 0 0 0 5 5 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 1 0 0 0 0 0 0 5 6 0 0 1 0 0 0 1 0 0 0 4
0 0 0 0 1 0 1 0 0 0 0 5 6 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 1 0 2 0 0 0 0 ffffffffffffffff 1 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 1 0 2 0 0 0 0 1 ffffffffffffffff 0 0 1 0 0 0 1 0 0 0 4
0 0 0 0 1 0 3 0 0 0 0 3 3 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 1 0 3 0 0 0 0 ffffffffffffffff 1 0 0 1 0 0 0 1 0 0 0 4
0 0 0 0 1 0 4 0 0 0 0 ffffffffffffffff 1 0 0 1 0 0 0 1 0 0 0 4
0 0 0 0 1 0 4 0 0 0 0 1 ffffffffffffffff 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 1 0 5 0 0 0 0 ffffffffffffffff 1 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 1 0 5 0 0 0 0 2 2 0 0 1 0 0 0 1 0 0 1 4
0 0 0 0 0 1 2 0 0 0 0 ffffffffffffffff 1 0 0 1 0 0 0 1 1 0 0 5
0 0 0 0 0 1 4 0 0 0 0 ffffffffffffffff 1 0 0 1 0 0 0 1 0 0 0 5
0 1 0 0 0 1 4 0 0 0 0 3 0 ffffffffffffffff 0 1 0 0 0 1 1 0 0 5
1 1 0 0 0 0 0 0 0 0 1000 0 0 800 0 1 0 0 0 1 0 1800 0 6
0 1 0 0 0 0 0 0 0 0 1000 2000 0 fffffffffffffffc 0 1 0 0 0 1 0 1ffc 0 6
0 0 0 0 0 0 0 1 0 0 0 1 7f 0 0 1 0 0 0 1 8000000000000000 0 0 5
0 0 0 0 0 0 0 1 1 0 0 8000000000000000 4 0 0 1 0 0 0 1 0800000000000000 0 0 5
0 0 0 0 0 0 0 1 2 0 0 8000000000000000 4 0 0 1 0 0 0 1 f800000000000000 0 0 5
0 0 0 0 0 0 0 1 0 1 0 3 ff 0 4 1 0 0 0 1 30 0 0 5
0 0 0 0 0 0 0 1 1 1 0 ff00 0 0 8 1 0 0 0 1 ff 0 0 5
0 0 0 0 0 0 0 1 2 1 0 fffffffffffff000 0 0 c 1 0 0 0 1 ffffffffffffffff 0 0 5
0 0 0 1 0 0 0 1 0 0 0 1 1f 0 0 1 0 0 0 1 ffffffff80000000 0 0 5
0 0 0 1 0 0 0 1 1 1 0 5555555580000000 0 0 4 1 0 0 0 1 8000000 0 0 5
0 0 0 1 0 0 0 1 2 0 0 80000000 4 0 0 1 0 0 0 1 fffffffff8000000 0 0 5
0 0 0 1 0 0 0 0 0 0 0 7fffffff 1 0 0 1 0 0 0 1 ffffffff80000000 0 0 5
0 0 1 1 0 0 0 0 0 0 0 100000000 1 0 0 1 0 0 0 1 ffffffffffffffff 0 0 5
0 0 0 0 0 0 0 0 0 0 0 10 20 0 0 1 0 0 0 1 30 30 0 7
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 1 30 30 0 7
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 0 1 1 30 30 0 7
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 1 1 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 1 2 0 0 1 0 0 0 1 3 3 0 7
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 1 1 1 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 0 0 0 0 0
0 0 0 0 0 0 0 0 0 0 0 a b 0 0 1 0 0 0 1 15 15 0 7

// ==== ex_stage.f ====
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_branchjudge.sv
verilog/ex_shifter.sv
verilog/ex_top.sv
verilog/ex_stage_reg.sv
verilog/ex_stage.sv
dv/ex_checker.sv
dv/ex_stage_tb.sv

// ==== Makefile ====
# Verilator build for the execute stage testbench
# run from the project root, the testbench reads dv/ex_cases.txt

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Test passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up as a line of its own
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
